// File: src/lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// address and data bus widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32

// byte offset bits within a 32-bit word
`define LSU_OFFS_W 2

// cache index width, two lines by default
// resize the cache here and nowhere else
`define LSU_IDX_W 1

// cacheable window, base included and limit excluded
`define LSU_CACHE_BASE 32'h8000_0000
`define LSU_CACHE_LIMIT 32'h8040_0000

// tag width follows from the values above
`define LSU_TAG_W (`LSU_ADDR_W - `LSU_IDX_W - `LSU_OFFS_W)

// number of cache lines
`define LSU_LINES (1 << `LSU_IDX_W)

// byte strobe width
`define LSU_STRB_W (`LSU_DATA_W / 8)

`endif

// File: src/lsu_op_pkg.sv
package lsu_op_pkg;

  // bit 3 marks a store, bits 1:0 give the access width
  typedef enum logic [3:0] {
    LB  = 4'h0,
    LH  = 4'h1,
    LW  = 4'h2,
    LBU = 4'h4,
    LHU = 4'h5,
    SB  = 4'h8,
    SH  = 4'h9,
    SW  = 4'ha
  } mem_op_e;

  // access width, log2 of the byte count
  typedef logic [1:0] mem_size_t;

  localparam mem_size_t SIZE_B = 2'd0;
  localparam mem_size_t SIZE_H = 2'd1;
  localparam mem_size_t SIZE_W = 2'd2;

  function automatic mem_size_t op_size(mem_op_e op);
    return mem_size_t'(op[1:0]);
  endfunction

  function automatic logic is_store(mem_op_e op);
    return op[3];
  endfunction

endpackage

// File: src/lsu_bus_pkg.sv
`include "lsu_macros.svh"

package lsu_bus_pkg;

  // bus-side address and data words
  typedef logic [`LSU_ADDR_W-1:0] addr_t;
  typedef logic [`LSU_DATA_W-1:0] data_t;

  // one bit per byte lane
  typedef logic [`LSU_STRB_W-1:0] strb_t;

  // address bits above index and byte offset
  typedef logic [`LSU_TAG_W-1:0] tag_t;

  // bus master sequencing
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    READ,
    WRITE,
    DONE
  } bus_state_e;

endpackage

// File: src/lsu_mem_if.sv
`timescale 1ns/100ps

interface lsu_mem_if;

  // load channel as seen by the cache
  lsu_bus_pkg::addr_t araddr;
  logic               arvalid;
  logic               rvalid;
  // word captured by the master, hit data or bus data
  lsu_bus_pkg::data_t rdata_raw;

  // cache lookup result
  logic               hit;
  lsu_bus_pkg::data_t cache_rdata;

  // store side, used for line invalidation
  lsu_bus_pkg::addr_t awaddr;
  logic               store_en;

  modport master (
    output araddr,
    output arvalid,
    output rvalid,
    output rdata_raw,
    output awaddr,
    output store_en,
    input  hit,
    input  cache_rdata
  );

  modport cache (
    input  araddr,
    input  arvalid,
    input  rvalid,
    input  rdata_raw,
    input  awaddr,
    input  store_en,
    output hit,
    output cache_rdata
  );

endinterface

// File: src/lsu_req_stage.sv
`timescale 1ns/100ps

module lsu_req_stage (
  input  logic                  clk,
  input  logic                  reset_i,
  // from execute
  input  logic                  req_valid_i,
  input  lsu_bus_pkg::addr_t    req_addr_i,
  input  lsu_op_pkg::mem_op_e   req_op_i,
  input  lsu_bus_pkg::data_t    req_wdata_i,
  // completion from the bus master
  input  logic                  done_i,
  output logic                  busy_o,
  // held request
  output logic                  req_pending_o,
  output lsu_bus_pkg::addr_t    addr_o,
  output lsu_op_pkg::mem_op_e   op_o,
  output lsu_bus_pkg::data_t    wdata_o
);

  logic                pending_q;
  logic                accept;
  lsu_bus_pkg::addr_t  addr_q;
  lsu_op_pkg::mem_op_e op_q;
  lsu_bus_pkg::data_t  wdata_q;

  // one request in flight, so take a new one only while idle
  assign accept = req_valid_i & ~pending_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pending_q <= 1'b0;
    end else if (accept) begin
      pending_q <= 1'b1;
    end else if (done_i) begin
      pending_q <= 1'b0;
    end
  end

  // payload stays put until the next acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= req_addr_i;
      op_q    <= req_op_i;
      wdata_q <= req_wdata_i;
    end
  end

  // busy stays up through the done cycle
  assign busy_o        = pending_q;
  assign req_pending_o = pending_q;
  assign addr_o        = addr_q;
  assign op_o          = op_q;
  assign wdata_o       = wdata_q;

endmodule

// File: src/lsu_load_path.sv
`timescale 1ns/100ps
`include "lsu_macros.svh"

module lsu_load_path (
  input  logic                clk,
  input  logic                reset_i,
  lsu_mem_if.cache            mem,
  // held request
  input  lsu_bus_pkg::addr_t  addr_i,
  input  lsu_op_pkg::mem_op_e op_i,
  // register value for the load
  output lsu_bus_pkg::data_t  rdata_o
);

  lsu_bus_pkg::data_t       data_q [`LSU_LINES];
  lsu_bus_pkg::tag_t        tag_q  [`LSU_LINES];
  logic [`LSU_LINES-1:0]    valid_q;

  logic [`LSU_IDX_W-1:0]    rd_idx;
  logic [`LSU_IDX_W-1:0]    fill_idx;
  logic [`LSU_IDX_W-1:0]    inv_idx;
  lsu_bus_pkg::tag_t        rd_tag;
  lsu_bus_pkg::tag_t        fill_tag;
  lsu_bus_pkg::tag_t        inv_tag;
  logic                     fill_en;
  logic                     inv_en;
  lsu_bus_pkg::data_t       shifted;

  function automatic logic in_window(lsu_bus_pkg::addr_t a);
    return (a >= `LSU_CACHE_BASE) && (a < `LSU_CACHE_LIMIT);
  endfunction

  // split addresses into tag and index
  assign rd_idx   = addr_i[`LSU_IDX_W+`LSU_OFFS_W-1:`LSU_OFFS_W];
  assign rd_tag   = addr_i[`LSU_ADDR_W-1:`LSU_IDX_W+`LSU_OFFS_W];
  assign fill_idx = mem.araddr[`LSU_IDX_W+`LSU_OFFS_W-1:`LSU_OFFS_W];
  assign fill_tag = mem.araddr[`LSU_ADDR_W-1:`LSU_IDX_W+`LSU_OFFS_W];
  assign inv_idx  = mem.awaddr[`LSU_IDX_W+`LSU_OFFS_W-1:`LSU_OFFS_W];
  assign inv_tag  = mem.awaddr[`LSU_ADDR_W-1:`LSU_IDX_W+`LSU_OFFS_W];

  assign mem.hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag) && in_window(addr_i);
  assign mem.cache_rdata = data_q[rd_idx];

  // fill on an accepted read response inside the window
  assign fill_en = mem.arvalid & mem.rvalid & in_window(mem.araddr);
  // write-around, a store only drops a matching line
  assign inv_en  = mem.store_en & valid_q[inv_idx] & (tag_q[inv_idx] == inv_tag);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (fill_en) begin
      valid_q[fill_idx] <= 1'b1;
    end else if (inv_en) begin
      valid_q[inv_idx] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      data_q[fill_idx] <= mem.rdata_raw;
      tag_q[fill_idx]  <= fill_tag;
    end
  end

  always_comb begin
    // byte offset moves the addressed byte to lane 0
    shifted = mem.rdata_raw >> {addr_i[`LSU_OFFS_W-1:0], 3'b000};
    case (op_i)
      lsu_op_pkg::LB:  rdata_o = {{(`LSU_DATA_W-8){shifted[7]}}, shifted[7:0]};
      lsu_op_pkg::LBU: rdata_o = {{(`LSU_DATA_W-8){1'b0}}, shifted[7:0]};
      lsu_op_pkg::LH:  rdata_o = {{(`LSU_DATA_W-16){shifted[15]}}, shifted[15:0]};
      lsu_op_pkg::LHU: rdata_o = {{(`LSU_DATA_W-16){1'b0}}, shifted[15:0]};
      default:         rdata_o = shifted;
    endcase
  end

endmodule

// File: src/lsu_bus_master.sv
`timescale 1ns/100ps

module lsu_bus_master (
  input  logic                clk,
  input  logic                reset_i,
  lsu_mem_if.master           mem,
  // held request
  input  logic                req_pending_i,
  input  lsu_bus_pkg::addr_t  addr_i,
  input  lsu_op_pkg::mem_op_e op_i,
  input  lsu_bus_pkg::data_t  wdata_i,
  // load channel
  output lsu_bus_pkg::addr_t  araddr_o,
  output logic                arvalid_o,
  output lsu_bus_pkg::strb_t  rstrb_o,
  input  lsu_bus_pkg::data_t  rdata_i,
  input  logic                rvalid_i,
  // store channel
  output lsu_bus_pkg::addr_t  awaddr_o,
  output logic                awvalid_o,
  output lsu_bus_pkg::data_t  wdata_o,
  output lsu_bus_pkg::strb_t  wstrb_o,
  output logic                wvalid_o,
  input  logic                wready_i,
  // one pulse per request
  output logic                done_o
);

  lsu_bus_pkg::bus_state_e state_q;
  lsu_bus_pkg::bus_state_e state_d;
  lsu_bus_pkg::strb_t      strb;
  lsu_bus_pkg::data_t      raw_q;
  logic                    store;

  assign store = lsu_op_pkg::is_store(op_i);

  // strobe from access width, not shifted by the offset
  always_comb begin
    case (lsu_op_pkg::op_size(op_i))
      lsu_op_pkg::SIZE_B: strb = 4'h1;
      lsu_op_pkg::SIZE_H: strb = 4'h3;
      default:            strb = 4'hf;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      lsu_bus_pkg::IDLE: begin
        if (req_pending_i) begin
          state_d = store ? lsu_bus_pkg::WRITE : lsu_bus_pkg::LOOKUP;
        end
      end
      lsu_bus_pkg::LOOKUP: begin
        // a miss already drives arvalid here, so a fast response counts
        if (mem.hit || rvalid_i) begin
          state_d = lsu_bus_pkg::DONE;
        end else begin
          state_d = lsu_bus_pkg::READ;
        end
      end
      lsu_bus_pkg::READ:  if (rvalid_i) state_d = lsu_bus_pkg::DONE;
      lsu_bus_pkg::WRITE: if (wready_i) state_d = lsu_bus_pkg::DONE;
      default:            state_d = lsu_bus_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= lsu_bus_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // word for the load path, kept through the done cycle
  always_ff @(posedge clk) begin
    if (state_q == lsu_bus_pkg::LOOKUP && mem.hit) begin
      raw_q <= mem.cache_rdata;
    end else if (arvalid_o && rvalid_i) begin
      raw_q <= rdata_i;
    end
  end

  assign arvalid_o = (state_q == lsu_bus_pkg::LOOKUP && !mem.hit) ||
                     (state_q == lsu_bus_pkg::READ);
  assign araddr_o  = addr_i;
  assign rstrb_o   = store ? '0 : strb;

  assign awvalid_o = (state_q == lsu_bus_pkg::WRITE);
  assign wvalid_o  = (state_q == lsu_bus_pkg::WRITE);
  assign awaddr_o  = addr_i;
  assign wdata_o   = wdata_i;
  assign wstrb_o   = store ? strb : '0;

  assign done_o    = (state_q == lsu_bus_pkg::DONE);

  // cache side of the interface
  assign mem.araddr    = addr_i;
  assign mem.arvalid   = arvalid_o;
  assign mem.rvalid    = rvalid_i;
  // bus data passes straight through on the response edge for the fill
  assign mem.rdata_raw = (arvalid_o && rvalid_i) ? rdata_i : raw_q;
  assign mem.awaddr    = addr_i;
  assign mem.store_en  = awvalid_o & wready_i;

endmodule

// File: src/lsu_top.sv
`timescale 1ns/100ps

module lsu_top (
  input  logic                clk,
  input  logic                reset_i,
  // execute side
  input  logic                req_valid_i,
  input  lsu_bus_pkg::addr_t  req_addr_i,
  input  lsu_op_pkg::mem_op_e req_op_i,
  input  lsu_bus_pkg::data_t  req_wdata_i,
  output logic                busy_o,
  output logic                done_o,
  output lsu_bus_pkg::data_t  rdata_o,
  // bus load channel
  output lsu_bus_pkg::addr_t  araddr_o,
  output logic                arvalid_o,
  output lsu_bus_pkg::strb_t  rstrb_o,
  input  lsu_bus_pkg::data_t  rdata_i,
  input  logic                rvalid_i,
  // bus store channel
  output lsu_bus_pkg::addr_t  awaddr_o,
  output logic                awvalid_o,
  output lsu_bus_pkg::data_t  wdata_o,
  output lsu_bus_pkg::strb_t  wstrb_o,
  output logic                wvalid_o,
  input  logic                wready_i
);

  logic                req_pending;
  lsu_bus_pkg::addr_t  held_addr;
  lsu_op_pkg::mem_op_e held_op;
  lsu_bus_pkg::data_t  held_wdata;

  lsu_mem_if u_mem_if ();

  lsu_req_stage u_req_stage (
    .clk           (clk),
    .reset_i       (reset_i),
    .req_valid_i   (req_valid_i),
    .req_addr_i    (req_addr_i),
    .req_op_i      (req_op_i),
    .req_wdata_i   (req_wdata_i),
    .done_i        (done_o),
    .busy_o        (busy_o),
    .req_pending_o (req_pending),
    .addr_o        (held_addr),
    .op_o          (held_op),
    .wdata_o       (held_wdata)
  );

  lsu_load_path u_load_path (
    .clk     (clk),
    .reset_i (reset_i),
    .mem     (u_mem_if.cache),
    .addr_i  (held_addr),
    .op_i    (held_op),
    .rdata_o (rdata_o)
  );

  lsu_bus_master u_bus_master (
    .clk           (clk),
    .reset_i       (reset_i),
    .mem           (u_mem_if.master),
    .req_pending_i (req_pending),
    .addr_i        (held_addr),
    .op_i          (held_op),
    .wdata_i       (held_wdata),
    .araddr_o      (araddr_o),
    .arvalid_o     (arvalid_o),
    .rstrb_o       (rstrb_o),
    .rdata_i       (rdata_i),
    .rvalid_i      (rvalid_i),
    .awaddr_o      (awaddr_o),
    .awvalid_o     (awvalid_o),
    .wdata_o       (wdata_o),
    .wstrb_o       (wstrb_o),
    .wvalid_o      (wvalid_o),
    .wready_i      (wready_i),
    .done_o        (done_o)
  );

endmodule

// File: tb/lsu_checker.sv
`timescale 1ns/100ps

module lsu_checker (
  input logic               clk,
  input logic               reset_i,
  input logic               busy_o,
  input logic               done_o,
  input lsu_bus_pkg::addr_t araddr_o,
  input logic               arvalid_o,
  input logic               rvalid_i,
  input lsu_bus_pkg::addr_t awaddr_o,
  input logic               awvalid_o,
  input lsu_bus_pkg::data_t wdata_o,
  input lsu_bus_pkg::strb_t wstrb_o,
  input logic               wvalid_o,
  input logic               wready_i
);

  int fail_count = 0;

  // no bus traffic while idle
  idle_quiet: assert property (@(posedge clk) disable iff (reset_i)
    !busy_o |-> !arvalid_o && !awvalid_o && !wvalid_o)
    else begin
      $error("bus valid high while the unit is idle");
      fail_count++;
    end

  // load and store channels never active together
  no_overlap: assert property (@(posedge clk) disable iff (reset_i)
    !(arvalid_o && awvalid_o))
    else begin
      $error("arvalid_o and awvalid_o high in the same cycle");
      fail_count++;
    end

  load_stable: assert property (@(posedge clk) disable iff (reset_i)
    arvalid_o && !rvalid_i |=> arvalid_o && $stable(araddr_o))
    else begin
      $error("load request dropped or changed before rvalid_i");
      fail_count++;
    end

  store_stable: assert property (@(posedge clk) disable iff (reset_i)
    awvalid_o && !wready_i |=> awvalid_o && wvalid_o && $stable(awaddr_o) &&
      $stable(wdata_o) && $stable(wstrb_o))
    else begin
      $error("store request dropped or changed before wready_i");
      fail_count++;
    end

  // done is a single pulse inside a busy period
  done_pulse: assert property (@(posedge clk) disable iff (reset_i)
    done_o |-> busy_o ##1 !done_o)
    else begin
      $error("done_o longer than one cycle or outside a request");
      fail_count++;
    end

endmodule

// File: tb/lsu_tb.sv
`timescale 1ns/100ps

module lsu_tb;

  localparam int LIMIT = 200;

  logic clk = 1'b0;
  logic reset_i = 1'b1;
  logic req_valid_i = 1'b0;
  logic [31:0] req_addr_i = '0;
  lsu_op_pkg::mem_op_e req_op_i = lsu_op_pkg::LW;
  logic [31:0] req_wdata_i = '0;
  logic [31:0] rdata_i = '0;
  logic rvalid_i = 1'b0;
  logic wready_i = 1'b0;
  logic busy_o, done_o, arvalid_o, awvalid_o, wvalid_o;
  logic [31:0] rdata_o, araddr_o, awaddr_o, wdata_o;
  logic [3:0] rstrb_o, wstrb_o;

  // memory model and its shadow, keyed by word address
  logic [31:0] mem_model [logic [29:0]];
  logic [31:0] shadow [logic [29:0]];
  logic [31:0] lat_state = 32'd31978;
  logic [31:0] stim_state = 32'd31978;
  int rd_wait = 0;
  int wr_wait = 0;
  logic hung = 1'b0;
  logic [31:0] got_rdata;
  int ar_cycles, done_edge;
  logic [3:0] seen_strb;
  logic [3:0] seen_rstrb;
  int test_errors = 0;
  int total_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  lsu_top u_lsu_top (.*);

  bind lsu_top lsu_checker u_lsu_checker (
    .clk(clk), .reset_i(reset_i), .busy_o(busy_o), .done_o(done_o),
    .araddr_o(araddr_o), .arvalid_o(arvalid_o), .rvalid_i(rvalid_i),
    .awaddr_o(awaddr_o), .awvalid_o(awvalid_o), .wdata_o(wdata_o),
    .wstrb_o(wstrb_o), .wvalid_o(wvalid_o), .wready_i(wready_i)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(inout logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // untouched memory reads back a pattern of the whole address
  function automatic logic [31:0] fill_word(logic [29:0] w);
    return {w[13:0], 2'b01, w[29:14]} ^ 32'h6d2b_79f5;
  endfunction

  function automatic logic [31:0] merge(logic [31:0] old, logic [31:0] d, logic [3:0] strb);
    logic [31:0] r;
    r = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) r[8*i +: 8] = d[8*i +: 8];
    end
    return r;
  endfunction

  function automatic logic [3:0] op_strobe(lsu_op_pkg::mem_op_e op);
    case (op)
      lsu_op_pkg::LB, lsu_op_pkg::LBU, lsu_op_pkg::SB: return 4'h1;
      lsu_op_pkg::LH, lsu_op_pkg::LHU, lsu_op_pkg::SH: return 4'h3;
      default:                                         return 4'hf;
    endcase
  endfunction

  function automatic logic [31:0] load_expect(lsu_op_pkg::mem_op_e op, logic [31:0] a);
    logic [31:0] w;
    logic [31:0] s;
    w = shadow.exists(a[31:2]) ? shadow[a[31:2]] : fill_word(a[31:2]);
    s = w >> (8 * a[1:0]);
    case (op)
      lsu_op_pkg::LB:  return {{24{s[7]}}, s[7:0]};
      lsu_op_pkg::LBU: return {24'h0, s[7:0]};
      lsu_op_pkg::LH:  return {{16{s[15]}}, s[15:0]};
      lsu_op_pkg::LHU: return {16'h0, s[15:0]};
      default:         return s;
    endcase
  endfunction

  // bus responder, latency 0 to 3 cycles
  always @(negedge clk) begin
    logic [31:0] old;
    rvalid_i = 1'b0;
    wready_i = 1'b0;
    if (!reset_i && arvalid_o) begin
      if (rd_wait == 0) begin
        rvalid_i = 1'b1;
        rdata_i = mem_model.exists(araddr_o[31:2]) ? mem_model[araddr_o[31:2]]
                                                   : fill_word(araddr_o[31:2]);
        rd_wait = xorshift(lat_state) % 4;
      end else begin
        rd_wait--;
      end
    end
    if (!reset_i && awvalid_o && wvalid_o) begin
      if (wr_wait == 0) begin
        wready_i = 1'b1;
        old = mem_model.exists(awaddr_o[31:2]) ? mem_model[awaddr_o[31:2]]
                                               : fill_word(awaddr_o[31:2]);
        mem_model[awaddr_o[31:2]] = merge(old, wdata_o, wstrb_o);
        wr_wait = xorshift(lat_state) % 4;
      end else begin
        wr_wait--;
      end
    end
  end

  task automatic preload(logic [31:0] a, logic [31:0] w);
    mem_model[a[31:2]] = w;
    shadow[a[31:2]] = w;
  endtask

  task automatic do_req(lsu_op_pkg::mem_op_e op, logic [31:0] a, logic [31:0] d);
    int cnt;
    if (hung) return;
    cnt = 0;
    @(negedge clk);
    while (busy_o && cnt < LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (busy_o) begin
      $display("timeout waiting for the unit to become idle");
      hung = 1'b1;
      return;
    end
    req_valid_i = 1'b1;
    req_op_i = op;
    req_addr_i = a;
    req_wdata_i = d;
    @(posedge clk);
    @(negedge clk);
    req_valid_i = 1'b0;
    ar_cycles = 0;
    seen_strb = 4'h0;
    seen_rstrb = 4'h0;
    done_edge = 0;
    cnt = 0;
    while (!done_o && cnt < LIMIT) begin
      if (arvalid_o) begin
        ar_cycles++;
        seen_rstrb = rstrb_o;
      end
      if (awvalid_o) seen_strb = wstrb_o;
      @(negedge clk);
      done_edge++;
      cnt++;
    end
    if (!done_o) begin
      $display("timeout waiting for done_o");
      hung = 1'b1;
      return;
    end
    got_rdata = rdata_o;
  endtask

  task automatic check_load(lsu_op_pkg::mem_op_e op, logic [31:0] a);
    logic [31:0] exp;
    do_req(op, a, 32'h0);
    exp = load_expect(op, a);
    if (!hung) begin
      assert (got_rdata === exp) else begin
        $display("mismatch rdata_o: expected %h, got %h", exp, got_rdata);
        test_errors++;
      end
    end
    if (!hung && ar_cycles != 0) begin
      assert (seen_rstrb === op_strobe(op)) else begin
        $display("mismatch rstrb_o: expected %h, got %h", op_strobe(op), seen_rstrb);
        test_errors++;
      end
    end
  endtask

  task automatic check_store(lsu_op_pkg::mem_op_e op, logic [31:0] a, logic [31:0] d);
    logic [31:0] old;
    do_req(op, a, d);
    old = shadow.exists(a[31:2]) ? shadow[a[31:2]] : fill_word(a[31:2]);
    shadow[a[31:2]] = merge(old, d, op_strobe(op));
    if (!hung) begin
      assert (seen_strb === op_strobe(op)) else begin
        $display("mismatch wstrb_o: expected %h, got %h", op_strobe(op), seen_strb);
        test_errors++;
      end
    end
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (test_errors != 0) tests_failed++;
    total_errors += test_errors;
    $display("%-16s %s (%0d errors)", name, test_errors == 0 ? "ok" : "FAILED", test_errors);
    test_errors = 0;
  endtask

  initial begin
    lsu_op_pkg::mem_op_e loads [5];
    logic [31:0] r;
    loads = '{lsu_op_pkg::LB, lsu_op_pkg::LBU, lsu_op_pkg::LH, lsu_op_pkg::LHU, lsu_op_pkg::LW};
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    repeat (4) @(negedge clk);
    end_test("reset_idle");

    // negative bytes and halfwords at every offset
    preload(32'h0000_1000, 32'h80ff_7f81);
    for (int i = 0; i < 5; i++) begin
      for (int off = 0; off < 4; off++) begin
        check_load(loads[i], 32'h0000_1000 + off);
        if (!hung && ar_cycles == 0) begin
          $display("load outside the cacheable window skipped the bus");
          test_errors++;
        end
      end
    end
    end_test("load_align");

    check_store(lsu_op_pkg::SW, 32'h0000_2000, 32'h1122_3344);
    check_store(lsu_op_pkg::SB, 32'h0000_2000, 32'hffff_ff5a);
    check_load(lsu_op_pkg::LW, 32'h0000_2000);
    check_store(lsu_op_pkg::SH, 32'h0000_2000, 32'hffff_beef);
    check_load(lsu_op_pkg::LW, 32'h0000_2000);
    end_test("store_merge");

    // random mix under random bus latency
    for (int n = 0; n < 16; n++) begin
      r = xorshift(stim_state);
      if (r[8]) check_store(lsu_op_pkg::mem_op_e'({2'b10, 2'(r[1:0] % 3)}),
                            32'h0000_3000 + (r[6:2] << 2), xorshift(stim_state));
      else check_load(loads[r[11:9] % 5], 32'h0000_3000 + (r[6:2] << 2) + r[13:12]);
    end
    end_test("backpressure");

    check_load(lsu_op_pkg::LW, 32'h8000_0010);
    check_load(lsu_op_pkg::LW, 32'h8000_0010);
    if (!hung && (ar_cycles != 0 || done_edge != 2)) begin
      $display("repeated load was not a cache hit (%0d bus cycles, done at edge %0d)",
               ar_cycles, done_edge);
      test_errors++;
    end
    check_load(lsu_op_pkg::LB, 32'h8000_0013);
    end_test("cache_hit");

    check_store(lsu_op_pkg::SW, 32'h8000_0010, 32'hcafe_f00d);
    check_load(lsu_op_pkg::LW, 32'h8000_0010);
    if (!hung && ar_cycles == 0) begin
      $display("load after store to a cached line skipped the bus");
      test_errors++;
    end
    end_test("invalidate");

    total_errors += u_lsu_top.u_lsu_checker.fail_count;
    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, total_errors, u_lsu_top.u_lsu_checker.fail_count);
    if (hung || total_errors != 0) begin
      $display("Test failed");
    end else begin
      $display("Test passed");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+src
src/lsu_op_pkg.sv
src/lsu_bus_pkg.sv
src/lsu_mem_if.sv
src/lsu_req_stage.sv
src/lsu_load_path.sv
src/lsu_bus_master.sv
src/lsu_top.sv
tb/lsu_checker.sv
tb/lsu_tb.sv

// File: Makefile
# Verilator build and run for the load/store unit

VERILATOR   ?= verilator
TOP         ?= lsu_tb
FILELIST    ?= list.f
BUILD_DIR   ?= build
LOG         ?= $(BUILD_DIR)/sim.log
VFLAGS      ?= --binary --timing --assert
ERROR_LIMIT ?= 1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS ERROR_LIMIT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
	  echo "simulation reported failure"; exit 1; \
	elif ! grep -q "Test passed" $(LOG); then \
	  echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
